// File: src/rem_pkg.sv
//##############################
// shared widths, word types and encodings for the remainder unit
// operands are 8-bit two's complement, datapath runs one bit wider
// changing WORD_WIDTH also needs STEPS_WIDTH to cover WORD_WIDTH_LONG
//##############################

`default_nettype none

package rem_pkg;

    // operand and result width
    localparam int WORD_WIDTH      = 8;

    // one extra bit so that the negated minimum value is representable
    // e.g. -128 / 1 must be able to add +128 to the remainder
    localparam int WORD_WIDTH_LONG = WORD_WIDTH + 1;

    // step counter width, must hold WORD_WIDTH_LONG - 1
    localparam int STEPS_WIDTH     = 4;

    // port-level words
    typedef logic [WORD_WIDTH-1:0]      word_t;

    // internal divisor, increment and remainder
    typedef logic [WORD_WIDTH_LONG-1:0] word_long_t;

    // division step count
    typedef logic [STEPS_WIDTH-1:0]     steps_t;

    // first count of a calculation, counts down to zero
    // one step per bit of the long word
    localparam steps_t STEPS_INITIAL = steps_t'(WORD_WIDTH_LONG - 1);

    // controller states, LOAD -> CALC -> DONE -> LOAD
    typedef enum logic [1:0] {
        STATE_LOAD = 2'b00,
        STATE_CALC = 2'b10,
        STATE_DONE = 2'b11
    } state_t;

    // remainder update direction
    typedef enum logic {
        OP_ADD = 1'b0,
        OP_SUB = 1'b1
    } add_sub_t;

endpackage

`default_nettype wire

// File: src/rem_fsm.sv
//##############################
// load/calculate/done controller
// one operation in flight, input_ready and output_valid
// depend on the state only, never on the other side's handshake
//##############################

`timescale 1ns/1ns
`default_nettype none

module rem_fsm (
    input  wire  clock,
    input  wire  rst_n,

    input  wire  input_valid,
    output logic input_ready,

    output logic output_valid,
    input  wire  output_ready,

    input  wire  last_step,

    output logic load_inputs,
    output logic calculating
);

    rem_pkg::state_t state;
    rem_pkg::state_t state_next;

    // output transfer, frees the unit for the next operands
    logic read_outputs;

    // state register
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state <= rem_pkg::STATE_LOAD;
        end else begin
            state <= state_next;
        end
    end

    // handshake outputs straight from the state
    // accept when empty, present result when done
    assign input_ready  = (state == rem_pkg::STATE_LOAD);
    assign output_valid = (state == rem_pkg::STATE_DONE);

    // events, the datapath sees these rather than the state
    assign load_inputs  = input_ready && input_valid;
    assign read_outputs = output_valid && output_ready;
    // high for every division step
    assign calculating  = (state == rem_pkg::STATE_CALC);

    // transitions
    always_comb begin
        state_next = state;
        case (state)
            rem_pkg::STATE_LOAD: begin
                if (load_inputs) begin
                    state_next = rem_pkg::STATE_CALC;
                end
            end
            rem_pkg::STATE_CALC: begin
                // leave on the edge that ends the final step
                if (last_step) begin
                    state_next = rem_pkg::STATE_DONE;
                end
            end
            rem_pkg::STATE_DONE: begin
                // hold the result until it is read
                if (read_outputs) begin
                    state_next = rem_pkg::STATE_LOAD;
                end
            end
            default: begin
                state_next = rem_pkg::STATE_LOAD;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: src/rem_step_counter.sv
//##############################
// division step down-counter
// reloads on every input transfer, stops at zero
// last_step only asserts while calculating
//##############################

`timescale 1ns/1ns
`default_nettype none

module rem_step_counter (
    input  wire  clock,
    input  wire  rst_n,

    input  wire  load_inputs,
    input  wire  calculating,

    output logic last_step
);

    rem_pkg::steps_t step_count;

    // zero means the current step is the final one
    logic count_zero;

    assign count_zero = (step_count == '0);

    // one step per calculating cycle, no stalls
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            step_count <= rem_pkg::STEPS_INITIAL;
        end else if (load_inputs) begin
            step_count <= rem_pkg::STEPS_INITIAL;
        end else if (calculating && !count_zero) begin
            step_count <= step_count - 1'b1;
        end
    end

    // ninth calculating cycle after a load
    assign last_step = calculating && count_zero;

endmodule

`default_nettype wire

// File: src/rem_divisor_shifter.sv
//##############################
// divisor store and remainder increment shift register
// the load does the first shift, so the increment holds the divisor
// scaled by 2^count, valid only once it is representable in 9 bits
// divide_by_zero is sampled from the divisor at load time
//##############################

`timescale 1ns/1ns
`default_nettype none

module rem_divisor_shifter (
    input  wire                       clock,
    input  wire                       rst_n,

    input  wire                       load_inputs,
    input  wire                       calculating,
    input  wire rem_pkg::word_t       divisor,

    output rem_pkg::word_long_t       increment,
    output logic                      increment_valid,
    output logic                      divisor_sign,
    output logic                      divide_by_zero
);

    localparam int MSB = rem_pkg::WORD_WIDTH_LONG - 1;

    // sign-extended input divisor
    rem_pkg::word_long_t divisor_long;

    // divisor bits not yet moved into the increment
    rem_pkg::word_long_t divisor_store;

    // store holds nothing but copies of the sign
    logic store_all_sign;

    assign divisor_long = {divisor[rem_pkg::WORD_WIDTH-1], divisor};

    // divisor sign and zero flag, held until the next load
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            divisor_sign   <= 1'b0;
            divide_by_zero <= 1'b0;
        end else if (load_inputs) begin
            divisor_sign   <= divisor_long[MSB];
            divide_by_zero <= (divisor == '0);
        end
    end

    // payload shift registers
    always_ff @(posedge clock) begin
        if (load_inputs) begin
            // arithmetic shift right, lsb goes to the top of the increment
            divisor_store <= {divisor_long[MSB], divisor_long[MSB:1]};
            increment     <= {divisor_long[0], {(rem_pkg::WORD_WIDTH_LONG - 1){1'b0}}};
        end else if (calculating) begin
            // next divisor bit drops into the increment msb
            divisor_store <= {divisor_store[MSB], divisor_store[MSB:1]};
            increment     <= {divisor_store[0], increment[MSB:1]};
        end
    end

    // positive divisor leaves zeros behind, negative leaves ones
    always_comb begin
        if (divisor_sign) begin
            store_all_sign = (divisor_store == '1);
        end else begin
            store_all_sign = (divisor_store == '0);
        end
    end

    // usable once every significant bit has moved over
    // and the increment carries the right sign
    assign increment_valid = store_all_sign && (increment[MSB] == divisor_sign);

endmodule

`default_nettype wire

// File: src/rem_accumulator.sv
//##############################
// remainder register, driven toward zero one step at a time
// a step is dropped when it would overshoot past zero
// result carries the dividend's sign, as in C truncating division
//##############################

`timescale 1ns/1ns
`default_nettype none

module rem_accumulator (
    input  wire                       clock,
    input  wire                       rst_n,

    input  wire                       load_inputs,
    input  wire                       calculating,
    input  wire rem_pkg::word_t       dividend,

    input  wire rem_pkg::word_long_t  increment,
    input  wire                       increment_valid,
    input  wire                       divisor_sign,

    output rem_pkg::word_t            remainder
);

    localparam int MSB = rem_pkg::WORD_WIDTH_LONG - 1;

    rem_pkg::word_long_t remainder_long;
    logic                dividend_sign;

    rem_pkg::add_sub_t   add_sub;
    // second adder operand, inverted for subtraction
    rem_pkg::word_long_t operand_b;
    rem_pkg::word_long_t remainder_next;
    logic                remainder_overflow;
    logic                remainder_next_ok;

    // same signs move toward zero by subtracting, else by adding
    assign add_sub = (divisor_sign == dividend_sign) ? rem_pkg::OP_SUB : rem_pkg::OP_ADD;

    // one adder, subtract as a + ~b + 1
    always_comb begin
        if (add_sub == rem_pkg::OP_SUB) begin
            operand_b = ~increment;
        end else begin
            operand_b = increment;
        end
        remainder_next = remainder_long + operand_b
                       + rem_pkg::word_long_t'(add_sub == rem_pkg::OP_SUB);
        // signed overflow, like operand signs with a different result sign
        remainder_overflow = (remainder_long[MSB] == operand_b[MSB])
                          && (remainder_next[MSB] != remainder_long[MSB]);
    end

    // keep the step only if it stays on the dividend's side of zero
    assign remainder_next_ok = increment_valid && !remainder_overflow
                            && ((remainder_next[MSB] == dividend_sign)
                                || (remainder_next == '0));

    // remainder starts as the sign-extended dividend
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            remainder_long <= '0;
            dividend_sign  <= 1'b0;
        end else if (load_inputs) begin
            remainder_long <= {dividend[rem_pkg::WORD_WIDTH-1], dividend};
            dividend_sign  <= dividend[rem_pkg::WORD_WIDTH-1];
        end else if (calculating && remainder_next_ok) begin
            remainder_long <= remainder_next;
        end
    end

    // magnitude is below the divisor's, so 8 bits always suffice
    assign remainder = remainder_long[rem_pkg::WORD_WIDTH-1:0];

endmodule

`default_nettype wire

// File: src/remainder_signed.sv
//##############################
// signed 8-bit truncating remainder, ready/valid on both sides
// result valid 9 cycles after the input transfer
// only one operation in flight, a held result blocks new inputs
// divide by zero returns the dividend with divide_by_zero set
//##############################

`timescale 1ns/1ns
`default_nettype none

module remainder_signed (
    input  wire                  clock,
    input  wire                  rst_n,

    // operand side
    input  wire                  input_valid,
    output wire                  input_ready,
    input  wire rem_pkg::word_t  dividend,
    input  wire rem_pkg::word_t  divisor,

    // result side
    output wire                  output_valid,
    input  wire                  output_ready,
    output wire rem_pkg::word_t  remainder,
    output wire                  divide_by_zero
);

    // controller events
    wire load_inputs;
    wire calculating;
    wire last_step;

    // divisor path to remainder path
    wire rem_pkg::word_long_t increment;
    wire                      increment_valid;
    wire                      divisor_sign;

    // states and handshakes
    rem_fsm fsm_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .input_valid  (input_valid),
        .input_ready  (input_ready),
        .output_valid (output_valid),
        .output_ready (output_ready),
        .last_step    (last_step),
        .load_inputs  (load_inputs),
        .calculating  (calculating)
    );

    // counts the 9 division steps
    rem_step_counter step_counter_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .load_inputs (load_inputs),
        .calculating (calculating),
        .last_step   (last_step)
    );

    // increment generation and zero check
    rem_divisor_shifter divisor_shifter_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .load_inputs     (load_inputs),
        .calculating     (calculating),
        .divisor         (divisor),
        .increment       (increment),
        .increment_valid (increment_valid),
        .divisor_sign    (divisor_sign),
        .divide_by_zero  (divide_by_zero)
    );

    // remainder update
    rem_accumulator accumulator_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .load_inputs     (load_inputs),
        .calculating     (calculating),
        .dividend        (dividend),
        .increment       (increment),
        .increment_valid (increment_valid),
        .divisor_sign    (divisor_sign),
        .remainder       (remainder)
    );

endmodule

`default_nettype wire

// File: verif/tb_remainder_signed.sv
//##############################
// directed testbench for the signed remainder unit
// drives at rising edges, samples at falling edges
// expected values come from C-style truncating % on ints
//##############################

`timescale 1ns/1ns
`default_nettype none

module tb_remainder_signed;

    // sign table 8, divide by zero 4, extremes 4, latency 2, random 200
    localparam int NUM_OPS = 218;
    localparam int WAIT_LIMIT = 40;
    // rising edges from the input transfer to output_valid
    localparam int LATENCY_CYCLES = 9;

    logic clock;
    logic rst_n;
    logic input_valid;
    logic input_ready;
    logic output_valid;
    logic output_ready;
    logic divide_by_zero;
    rem_pkg::word_t dividend;
    rem_pkg::word_t divisor;
    rem_pkg::word_t remainder;

    int error_count;
    int check_count;
    logic [31:0] rng_state;

    remainder_signed dut_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .input_valid    (input_valid),
        .input_ready    (input_ready),
        .dividend       (dividend),
        .divisor        (divisor),
        .output_valid   (output_valid),
        .output_ready   (output_ready),
        .remainder      (remainder),
        .divide_by_zero (divide_by_zero)
    );

    // 8 ns period
    always #4 clock = ~clock;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // truncating remainder, a zero divisor hands back the dividend
    function automatic int model_remainder(input rem_pkg::word_t a, input rem_pkg::word_t b);
        int sa;
        int sb;
        sa = int'($signed(a));
        sb = int'($signed(b));
        if (sb == 0) begin
            return sa;
        end
        // 32-bit ints, so -128 % -1 cannot overflow
        return sa % sb;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("MISMATCH at %0t ns: %s expected %0d, got %0d",
                     $time, name, expected, actual);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // one full operation, returns at a falling edge after the read
    task automatic run_operation(input rem_pkg::word_t a, input rem_pkg::word_t b,
                                 input int gap);
        int exp_rem;
        int exp_dbz;
        int waited;
        int cycles;
        exp_rem = model_remainder(a, b);
        exp_dbz = (b == '0) ? 1 : 0;
        @(posedge clock);
        input_valid <= 1'b1;
        dividend    <= a;
        divisor     <= b;
        waited = 0;
        @(negedge clock);
        while (!input_ready && waited < WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        if (!input_ready) begin
            error_count++;
            $display("input_ready stayed low, operands could not be sent at %0t ns", $time);
        end
        // transfer edge, operands change right after to catch late sampling
        @(posedge clock);
        input_valid <= 1'b0;
        dividend    <= ~a;
        divisor     <= ~b;
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            @(negedge clock);
        end while (!output_valid && cycles < WAIT_LIMIT);
        if (!output_valid) begin
            error_count++;
            $display("output_valid never rose after the input transfer at %0t ns", $time);
        end
        check_value("latency", LATENCY_CYCLES, cycles);
        check_value("remainder", exp_rem, int'($signed(remainder)));
        check_value("divide_by_zero", exp_dbz, int'(divide_by_zero));
        check_value("input_ready", 0, int'(input_ready));
        // back-pressure, result must hold and no new input accepted
        repeat (gap) begin
            @(posedge clock);
            @(negedge clock);
            check_value("remainder", exp_rem, int'($signed(remainder)));
            check_value("divide_by_zero", exp_dbz, int'(divide_by_zero));
            check_value("output_valid", 1, int'(output_valid));
            check_value("input_ready", 0, int'(input_ready));
        end
        @(posedge clock);
        output_ready <= 1'b1;
        // output transfer happens on this edge
        @(posedge clock);
        output_ready <= 1'b0;
        @(negedge clock);
        check_value("output_valid", 0, int'(output_valid));
        check_value("input_ready", 1, int'(input_ready));
    endtask

    task automatic reset_values();
        int errors_before;
        errors_before = error_count;
        check_value("input_ready", 1, int'(input_ready));
        check_value("output_valid", 0, int'(output_valid));
        check_value("divide_by_zero", 0, int'(divide_by_zero));
        check_value("remainder", 0, int'($signed(remainder)));
        report_test("reset", errors_before);
    endtask

    task automatic sign_table();
        int errors_before;
        errors_before = error_count;
        run_operation(8'sd22, 8'sd7, 0);
        run_operation(8'sd22, -8'sd7, 0);
        run_operation(-8'sd22, 8'sd7, 0);
        run_operation(-8'sd22, -8'sd7, 0);
        run_operation(8'sd7, 8'sd22, 0);
        run_operation(8'sd7, -8'sd22, 0);
        run_operation(-8'sd7, 8'sd22, 0);
        run_operation(-8'sd7, -8'sd22, 0);
        report_test("sign table", errors_before);
    endtask

    task automatic divide_by_zero_cases();
        int errors_before;
        errors_before = error_count;
        run_operation(8'sd0, 8'sd0, 0);
        run_operation(8'sd22, 8'sd0, 1);
        run_operation(-8'sd22, 8'sd0, 0);
        // flag must drop again
        run_operation(8'sd22, 8'sd7, 0);
        report_test("divide by zero", errors_before);
    endtask

    task automatic extreme_operands();
        int errors_before;
        errors_before = error_count;
        run_operation(8'h80, 8'sd1, 0);
        run_operation(8'h80, 8'hff, 0);
        run_operation(8'h80, 8'sd127, 0);
        run_operation(8'sd127, 8'h80, 0);
        report_test("extremes", errors_before);
    endtask

    task automatic latency_and_backpressure();
        int errors_before;
        errors_before = error_count;
        rng_state = xorshift32(rng_state);
        run_operation(-8'sd100, 8'sd9, 5 + int'(rng_state[2:0]));
        rng_state = xorshift32(rng_state);
        run_operation(8'sd100, -8'sd9, 5 + int'(rng_state[2:0]));
        report_test("latency and back-pressure", errors_before);
    endtask

    task automatic random_operations();
        int errors_before;
        errors_before = error_count;
        repeat (200) begin
            rng_state = xorshift32(rng_state);
            // operands and read gap all from one draw
            run_operation(rng_state[7:0], rng_state[15:8], int'(rng_state[18:16]));
        end
        report_test("random operations", errors_before);
    endtask

    // limit scaled from the operation count
    initial begin
        repeat (NUM_OPS * 20 + 100) @(posedge clock);
        $display("timeout, the tests did not finish in %0d cycles", NUM_OPS * 20 + 100);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        input_valid  = 1'b0;
        output_ready = 1'b0;
        dividend     = '0;
        divisor      = '0;
        error_count  = 0;
        check_count  = 0;
        rng_state    = 32'd10034;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        reset_values();
        sign_table();
        divide_by_zero_cases();
        extreme_operands();
        latency_and_backpressure();
        random_operations();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
src/rem_pkg.sv
src/rem_fsm.sv
src/rem_step_counter.sv
src/rem_divisor_shifter.sv
src/rem_accumulator.sv
src/remainder_signed.sv
verif/tb_remainder_signed.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_remainder_signed \
    -o tb_remainder_signed > sim.log 2>&1 \
    && ./obj_dir/tb_remainder_signed >> sim.log 2>&1
grep -q "^NO ERRORS$" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
